/* run.sh */
#!/bin/sh
# build with Verilator and run; pass only if the pass line appears in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f rv_core.f -o sim_rv_core &&
./obj_dir/sim_rv_core | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* rv_core.f */
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_reg_file.sv
source/rv_lsu.sv
source/rv_control.sv
source/rv_core.sv
tests/tb_clock.sv
tests/tb_rv_core.sv

/* source/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  rv_core_pkg::alu_op_t op,
    output rv_core_pkg::word_t   y,
    output logic                 zero
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];    // shift amount from low bits only

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_sll:  y = a << shamt;
            alu_slt:  y = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: y = {31'b0, a < b};
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = word_t'($signed(a) >>> shamt);
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = a + b;
        endcase
    end

    assign zero = (y == '0);   // beq/bne look at this after a sub

endmodule

/* source/rv_control.sv */
`timescale 1ns/1ps

module rv_control #(
    parameter rv_core_pkg::word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::dec_t     dec,
    input  rv_core_pkg::word_t    alu_y,
    input  logic                  alu_zero,
    input  rv_core_pkg::word_t    wdata,
    input  rv_core_pkg::byte_en_t byte_en,
    input  rv_core_pkg::word_t    load_val,
    input  logic                  dtack,
    output rv_core_pkg::alu_op_t  alu_op,
    output logic                  use_imm,
    output logic                  rf_we,
    output rv_core_pkg::word_t    rf_wdata,
    output rv_core_pkg::bus_t     bus,
    output rv_core_pkg::word_t    pc,
    output logic                  halt
);
    import rv_core_pkg::*;

    typedef enum logic [2:0] {
        st_decode, st_execute, st_writeback, st_mem_wait, st_pc_update
    } state_t;

    state_t   state;
    dec_t     dec_q;       // instruction held from decode onward
    logic     taken;       // branch decision for pc update
    logic     cond;
    logic     mem_op;
    logic     misaligned;
    logic     as_n_q;
    logic     we_n_q;
    word_t    addr_q;
    word_t    wdata_q;
    byte_en_t be_q;

    assign alu_op  = dec_q.alu_op;
    assign use_imm = dec_q.use_imm;
    assign mem_op  = (dec_q.cls == cls_load) || (dec_q.cls == cls_store);

    // beq/bne test zero, ordered compares test the slt bit; funct3[0] inverts
    assign cond = (dec_q.funct3[2] ? alu_y[0] : alu_zero) ^ dec_q.funct3[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_decode;
            pc     <= reset_pc;
            halt   <= 1'b0;
            taken  <= 1'b0;
            as_n_q <= 1'b1;
            we_n_q <= 1'b1;
        end else begin
            case (state)
                st_decode: begin
                    if (dec.cls == cls_halt) begin
                        halt <= 1'b1;            // park here, pc frozen
                    end else begin
                        halt  <= 1'b0;
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (!mem_op) begin
                        state <= st_writeback;
                    end else if (!dtack) begin   // previous ack must be gone
                        as_n_q <= 1'b0;
                        we_n_q <= (dec_q.cls != cls_store);
                        state  <= st_mem_wait;
                    end
                end
                st_writeback: begin
                    taken <= (dec_q.cls == cls_branch) && cond;
                    state <= st_pc_update;
                end
                st_mem_wait: begin
                    if (dtack) begin
                        as_n_q <= 1'b1;
                        we_n_q <= 1'b1;
                        state  <= st_pc_update;
                    end
                end
                st_pc_update: begin
                    pc    <= taken ? pc + dec_q.imm : pc + 32'd4;
                    taken <= 1'b0;
                    state <= st_decode;
                end
                default: state <= st_decode;
            endcase
        end
    end

    // held instruction and bus payload
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            dec_q <= dec;
        end
        if (state == st_execute && mem_op && !dtack) begin
            addr_q  <= alu_y;
            wdata_q <= wdata;
            be_q    <= byte_en;
        end
    end

    assign rf_we = (state == st_writeback &&
                    (dec_q.cls == cls_alu || dec_q.cls == cls_lui)) ||
                   (state == st_mem_wait && dec_q.cls == cls_load && dtack);

    always_comb begin
        case (dec_q.cls)
            cls_load: rf_wdata = load_val;
            cls_lui:  rf_wdata = dec_q.imm;
            default:  rf_wdata = alu_y;
        endcase
    end

    // fetch shows pc on the address lines while the strobe is idle
    assign bus = '{addr: as_n_q ? pc : addr_q, wdata: wdata_q, byte_en: be_q,
                   we_n: we_n_q, as_n: as_n_q};

    assign misaligned = (dec_q.funct3[1:0] == 2'b01 && addr_q[0]) ||
                        (dec_q.funct3[1:0] == 2'b10 && addr_q[1:0] != 2'b00);

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_mem_wait) |-> !misaligned);

    // strobe only released on the edge where the ack was sampled
    a_as_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(as_n_q) |-> $past(dtack));

    a_no_store_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_mem_wait && dec_q.cls == cls_store) |-> !rf_we);

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter rv_core_pkg::word_t reset_pc  = '0,
    parameter int                 reg_count = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_core_pkg::word_t instruction,
    input  rv_core_pkg::word_t rdata,
    input  logic               dtack,
    output rv_core_pkg::bus_t  bus,
    output rv_core_pkg::word_t pc,
    output logic               halt
);
    import rv_core_pkg::*;

    dec_t     dec;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_b;
    word_t    alu_y;
    logic     alu_zero;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     rf_we;
    word_t    rf_wdata;
    word_t    st_wdata;
    byte_en_t st_byte_en;
    word_t    load_val;

    assign alu_b = use_imm ? dec.imm : rs2_val;   // operand b select

    rv_decoder u_decoder (.instruction(instruction), .dec(dec));

    rv_reg_file #(.reg_count(reg_count)) u_reg_file (
        .clk(clk), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd), .we(rf_we),
        .wdata(rf_wdata), .rs1_val(rs1_val), .rs2_val(rs2_val));

    rv_alu u_alu (.a(rs1_val), .b(alu_b), .op(alu_op), .y(alu_y), .zero(alu_zero));

    rv_lsu u_lsu (
        .addr(alu_y), .store_val(rs2_val), .funct3(dec.funct3), .rdata(rdata),
        .wdata(st_wdata), .byte_en(st_byte_en), .load_val(load_val));

    rv_control #(.reset_pc(reset_pc)) u_control (
        .clk(clk), .rst_n(rst_n), .dec(dec), .alu_y(alu_y), .alu_zero(alu_zero),
        .wdata(st_wdata), .byte_en(st_byte_en), .load_val(load_val), .dtack(dtack),
        .alu_op(alu_op), .use_imm(use_imm), .rf_we(rf_we), .rf_wdata(rf_wdata),
        .bus(bus), .pc(pc), .halt(halt));

endmodule

/* source/rv_core_pkg.sv */
package rv_core_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_idx_t;   // register index
    typedef logic [2:0]  funct3_t;    // access width or compare kind
    typedef logic [3:0]  byte_en_t;   // one enable per byte lane
    typedef logic [3:0]  alu_op_t;    // {funct7[5], funct3}

    // alu op codes, alternate bit on top of funct3
    localparam alu_op_t alu_add  = 4'b0000;
    localparam alu_op_t alu_sll  = 4'b0001;
    localparam alu_op_t alu_slt  = 4'b0010;
    localparam alu_op_t alu_sltu = 4'b0011;
    localparam alu_op_t alu_xor  = 4'b0100;
    localparam alu_op_t alu_srl  = 4'b0101;
    localparam alu_op_t alu_or   = 4'b0110;
    localparam alu_op_t alu_and  = 4'b0111;
    localparam alu_op_t alu_sub  = 4'b1000;
    localparam alu_op_t alu_sra  = 4'b1101;

    localparam logic [6:0] opc_r      = 7'b0110011;
    localparam logic [6:0] opc_i      = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_halt   = 7'b0000000;

    // load and store widths
    localparam funct3_t f3_byte   = 3'b000;
    localparam funct3_t f3_half   = 3'b001;
    localparam funct3_t f3_word   = 3'b010;
    localparam funct3_t f3_byte_u = 3'b100;
    localparam funct3_t f3_half_u = 3'b101;

    typedef enum logic [2:0] {
        cls_alu, cls_load, cls_store, cls_branch, cls_lui, cls_halt, cls_none
    } inst_class_t;

    typedef struct packed {
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        funct3_t     funct3;
        alu_op_t     alu_op;
        logic        use_imm;   // second alu operand is imm
        inst_class_t cls;
        word_t       imm;       // sign-extended, format already resolved
    } dec_t;

    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
        logic     we_n;         // low for a write
        logic     as_n;         // address strobe, low during an access
    } bus_t;

endpackage

/* source/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_core_pkg::word_t instruction,
    output rv_core_pkg::dec_t  dec
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic       alt;       // funct7 bit 5
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;

    assign opcode = instruction[6:0];
    assign alt    = instruction[30];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};  // bit 0 always zero
    assign imm_u = {instruction[31:12], 12'h000};

    always_comb begin
        dec         = '0;
        dec.rs1     = instruction[19:15];
        dec.rs2     = instruction[24:20];
        dec.rd      = instruction[11:7];
        dec.funct3  = instruction[14:12];
        dec.alu_op  = alu_add;
        dec.cls     = cls_none;
        case (opcode)
            opc_r: begin
                dec.cls    = cls_alu;
                dec.alu_op = {alt, dec.funct3};
            end
            opc_i: begin
                dec.cls     = cls_alu;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                // only srli/srai carry the alternate bit, addi has none
                dec.alu_op  = (dec.funct3[1:0] == 2'b01) ? {alt, dec.funct3}
                                                         : {1'b0, dec.funct3};
            end
            opc_load: begin
                dec.cls     = cls_load;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            opc_store: begin
                dec.cls     = cls_store;
                dec.use_imm = 1'b1;
                dec.imm     = imm_s;
            end
            opc_branch: begin
                dec.cls    = cls_branch;
                dec.imm    = imm_b;
                dec.alu_op = !dec.funct3[2] ? alu_sub      // beq, bne
                           : (dec.funct3[1] ? alu_sltu : alu_slt);
            end
            opc_lui: begin
                dec.cls = cls_lui;
                dec.imm = imm_u;
            end
            opc_halt: dec.cls = cls_halt;
            default:  dec.cls = cls_none;                  // unknown, runs as a nop
        endcase
    end

endmodule

/* source/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
    input  rv_core_pkg::word_t    addr,
    input  rv_core_pkg::word_t    store_val,
    input  rv_core_pkg::funct3_t  funct3,
    input  rv_core_pkg::word_t    rdata,
    output rv_core_pkg::word_t    wdata,
    output rv_core_pkg::byte_en_t byte_en,
    output rv_core_pkg::word_t    load_val
);
    import rv_core_pkg::*;

    logic [4:0] lane_shift;   // 8 times the byte offset
    word_t      lane;         // addressed bytes moved down to bit 0

    assign lane_shift = {addr[1:0], 3'b000};

    // store data moves up into the addressed lane
    assign wdata = store_val << lane_shift;

    always_comb begin
        case (funct3[1:0])
            2'b00:   byte_en = byte_en_t'(4'b0001 << addr[1:0]);   // sb
            2'b01:   byte_en = byte_en_t'(4'b0011 << addr[1:0]);   // sh
            default: byte_en = 4'b1111;                            // sw
        endcase
    end

    assign lane = rdata >> lane_shift;

    always_comb begin
        case (funct3)
            f3_byte:   load_val = {{24{lane[7]}}, lane[7:0]};
            f3_half:   load_val = {{16{lane[15]}}, lane[15:0]};
            f3_word:   load_val = rdata;
            f3_byte_u: load_val = {24'b0, lane[7:0]};
            f3_half_u: load_val = {16'b0, lane[15:0]};
            default:   load_val = rdata;
        endcase
    end

endmodule

/* source/rv_reg_file.sv */
`timescale 1ns/1ps

module rv_reg_file #(
    parameter int reg_count = 32   // 16 for rv32e
) (
    input  logic                  clk,
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    input  rv_core_pkg::reg_idx_t rd,
    input  logic                  we,
    input  rv_core_pkg::word_t    wdata,
    output rv_core_pkg::word_t    rs1_val,
    output rv_core_pkg::word_t    rs2_val
);
    import rv_core_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (we && rd != '0 && 32'(rd) < reg_count) begin   // x0 and missing regs drop writes
            regs[rd] <= wdata;
        end
    end

    assign rs1_val = (rs1 == '0 || 32'(rs1) >= reg_count) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0 || 32'(rs2) >= reg_count) ? '0 : regs[rs2];

    // x0 reads zero on both ports after any write
    a_x0_zero: assert property (@(posedge clk)
        we |=> ((rs1 != '0 || rs1_val == '0) && (rs2 != '0 || rs2_val == '0)));

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 2,   // 4 ns clock
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;   // released just after the edge, like the other inputs
    end

endmodule

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam word_t start_pc    = 32'h0000_0000;
    localparam int    prog_len    = 76;
    localparam int    wr_len      = 32;
    localparam int    drive_delay = 1;
    localparam int    halt_limit  = 3000;   // cycles allowed for the whole program

    // branch compare kinds
    localparam funct3_t br_eq  = 3'b000;
    localparam funct3_t br_ne  = 3'b001;
    localparam funct3_t br_lt  = 3'b100;
    localparam funct3_t br_ge  = 3'b101;
    localparam funct3_t br_ltu = 3'b110;
    localparam funct3_t br_geu = 3'b111;

    typedef struct packed {
        word_t    addr;
        byte_en_t be;
        word_t    data;
    } wr_t;

    logic  clk;
    logic  rst_n;
    word_t instruction;
    word_t rdata;
    logic  dtack;
    bus_t  bus;
    word_t pc;
    logic  halt;

    word_t prog [prog_len];
    wr_t   exp_wr [wr_len];
    wr_t   obs_wr [$];
    word_t mem [32];
    int    delay_tab [4];
    int    mismatch_count = 0;
    int    other_count = 0;
    logic  pending;
    int    wait_left;
    int    access_count;

    tb_clock clock_gen (.clk(clk), .rst_n(rst_n));

    rv_core #(.reset_pc(start_pc), .reg_count(32)) uut (
        .clk(clk), .rst_n(rst_n), .instruction(instruction), .rdata(rdata),
        .dtack(dtack), .bus(bus), .pc(pc), .halt(halt));

    function automatic word_t alu_rr(input alu_op_t op, input int rd, input int rs1,
                                     input int rs2);
        return {1'b0, op[3], 5'b0, 5'(rs2), 5'(rs1), op[2:0], 5'(rd), opc_r};
    endfunction

    function automatic word_t alu_ri(input alu_op_t op, input int rd, input int rs1,
                                     input int imm);
        logic [11:0] imm12;
        imm12 = 12'(imm) | {1'b0, op[3], 10'b0};   // srai carries funct7 bit 5
        return {imm12, 5'(rs1), op[2:0], 5'(rd), opc_i};
    endfunction

    function automatic word_t load_from(input funct3_t f3, input int rd, input int rs1,
                                        input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc_load};
    endfunction

    function automatic word_t store_to(input funct3_t f3, input int rs2, input int rs1,
                                       input int imm);
        logic [11:0] imm12;
        imm12 = 12'(imm);
        return {imm12[11:5], 5'(rs2), 5'(rs1), f3, imm12[4:0], opc_store};
    endfunction

    function automatic word_t branch_if(input funct3_t f3, input int rs1, input int rs2,
                                        input int offset);
        logic [12:0] imm13;
        imm13 = 13'(offset);
        return {imm13[12], imm13[10:5], 5'(rs2), 5'(rs1), f3, imm13[4:1], imm13[11],
                opc_branch};
    endfunction

    function automatic word_t upper_imm(input int rd, input int imm20);
        return {20'(imm20), 5'(rd), opc_lui};
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        return (idx < prog_len) ? prog[idx] : '0;   // past the end reads as halt
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    // instruction port answers the current pc
    initial begin
        instruction = '0;
        forever begin
            @(posedge clk);
            #drive_delay;
            instruction = fetch_word(pc);
        end
    end

    // data memory with a per-access dtack delay
    initial begin
        wr_t w;
        dtack        = 1'b0;
        rdata        = '0;
        pending      = 1'b0;
        wait_left    = 0;
        access_count = 0;
        delay_tab    = '{0, 3, 1, 2};
        for (int i = 0; i < 32; i++) begin
            mem[i] = 32'h5a00_0000 | word_t'(i << 2);
        end
        mem[24] = 32'h8f7e_c281;   // load source at 0x60
        forever begin
            @(posedge clk);
            #drive_delay;
            if (!rst_n) begin
                dtack   = 1'b0;
                pending = 1'b0;
            end else if (dtack) begin
                if (bus.as_n) begin
                    dtack = 1'b0;   // strobe released, cycle over
                end
            end else if (!bus.as_n) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = delay_tab[access_count % 4];
                end
                if (wait_left == 0) begin
                    if (!bus.we_n) begin
                        w = '{addr: bus.addr, be: bus.byte_en, data: bus.wdata};
                        obs_wr.push_back(w);
                        for (int b = 0; b < 4; b++) begin
                            if (bus.byte_en[b]) begin
                                mem[bus.addr[6:2]][8*b +: 8] = bus.wdata[8*b +: 8];
                            end
                        end
                    end else begin
                        rdata = mem[bus.addr[6:2]];
                    end
                    pending = 1'b0;
                    access_count++;
                    dtack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic wait_for_reset(output logic ok);
        int n;
        n = 0;
        while (!rst_n && n < 50) begin
            @(negedge clk);
            n++;
        end
        ok = rst_n;
        if (!ok) begin
            $display("reset was never released");
            other_count++;
        end
    endtask

    task automatic wait_for_halt(output logic ok);
        int n;
        n = 0;
        while (!halt && n < halt_limit) begin
            @(negedge clk);
            n++;
        end
        ok = halt;
        if (!ok) begin
            $display("the core did not halt within %0d cycles", halt_limit);
            other_count++;
        end
    endtask

    task automatic report_and_finish();
        $display("closing report: %0d mismatches, %0d other errors",
                 mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        logic  ok;
        word_t halt_pc;
        int    writes;
        prog = '{
            alu_ri(alu_add, 1, 0, 1234), alu_ri(alu_add, 2, 0, -77), alu_ri(alu_add, 4, 0, 33),
            alu_rr(alu_add, 3, 1, 2),    store_to(f3_word, 3, 0, 'h40),
            alu_rr(alu_sub, 3, 1, 2),    store_to(f3_word, 3, 0, 'h40),
            alu_rr(alu_xor, 3, 1, 2),    store_to(f3_word, 3, 0, 'h40),
            alu_rr(alu_or, 3, 1, 2),     store_to(f3_word, 3, 0, 'h40),
            alu_rr(alu_and, 3, 1, 2),    store_to(f3_word, 3, 0, 'h40),
            alu_rr(alu_slt, 3, 2, 1),    store_to(f3_word, 3, 0, 'h40),
            alu_rr(alu_sltu, 3, 2, 1),   store_to(f3_word, 3, 0, 'h40),
            alu_ri(alu_sll, 3, 1, 4),    store_to(f3_word, 3, 0, 'h40),
            alu_ri(alu_srl, 3, 2, 4),    store_to(f3_word, 3, 0, 'h40),
            alu_ri(alu_sra, 3, 2, 4),    store_to(f3_word, 3, 0, 'h40),
            alu_rr(alu_sra, 3, 2, 4),    store_to(f3_word, 3, 0, 'h40),
            upper_imm(7, 'h89abd),       alu_ri(alu_add, 7, 7, -529),
            store_to(f3_byte, 7, 0, 'h50), store_to(f3_byte, 7, 0, 'h51),
            store_to(f3_byte, 7, 0, 'h52), store_to(f3_byte, 7, 0, 'h53),
            store_to(f3_half, 7, 0, 'h54), store_to(f3_half, 7, 0, 'h56),
            upper_imm(5, 'habcde),       store_to(f3_word, 5, 0, 'h44),
            load_from(f3_byte, 8, 0, 'h60),   store_to(f3_word, 8, 0, 'h70),
            load_from(f3_byte, 8, 0, 'h62),   store_to(f3_word, 8, 0, 'h70),
            load_from(f3_byte_u, 8, 0, 'h61), store_to(f3_word, 8, 0, 'h70),
            load_from(f3_byte_u, 8, 0, 'h63), store_to(f3_word, 8, 0, 'h70),
            load_from(f3_half, 8, 0, 'h60),   store_to(f3_word, 8, 0, 'h70),
            load_from(f3_half, 8, 0, 'h62),   store_to(f3_word, 8, 0, 'h70),
            load_from(f3_half_u, 8, 0, 'h60), store_to(f3_word, 8, 0, 'h70),
            load_from(f3_word, 8, 0, 'h60),   store_to(f3_word, 8, 0, 'h70),
            branch_if(br_eq, 1, 1, 8),   store_to(f3_word, 1, 0, 'h00),   // taken
            branch_if(br_eq, 1, 2, 8),   store_to(f3_word, 1, 0, 'h04),
            branch_if(br_ne, 1, 2, 8),   store_to(f3_word, 1, 0, 'h08),   // taken
            branch_if(br_ne, 1, 1, 8),   store_to(f3_word, 1, 0, 'h0c),
            branch_if(br_lt, 2, 1, 8),   store_to(f3_word, 1, 0, 'h10),   // taken
            branch_if(br_lt, 1, 2, 8),   store_to(f3_word, 1, 0, 'h14),
            branch_if(br_ge, 1, 2, 8),   store_to(f3_word, 1, 0, 'h18),   // taken
            branch_if(br_ge, 2, 1, 8),   store_to(f3_word, 1, 0, 'h1c),
            branch_if(br_ltu, 1, 2, 8),  store_to(f3_word, 1, 0, 'h20),   // taken
            branch_if(br_ltu, 2, 1, 8),  store_to(f3_word, 1, 0, 'h24),
            branch_if(br_geu, 2, 1, 8),  store_to(f3_word, 1, 0, 'h28),   // taken
            branch_if(br_geu, 1, 2, 8),  store_to(f3_word, 1, 0, 'h2c),
            32'h0000_0000
        };
        // x1 = 1234, x2 = -77, x4 = 33
        exp_wr = '{
            '{32'h40, 4'hf, 32'h0000_0485}, '{32'h40, 4'hf, 32'h0000_051f},
            '{32'h40, 4'hf, 32'hffff_fb61}, '{32'h40, 4'hf, 32'hffff_fff3},
            '{32'h40, 4'hf, 32'h0000_0492}, '{32'h40, 4'hf, 32'h0000_0001},
            '{32'h40, 4'hf, 32'h0000_0000}, '{32'h40, 4'hf, 32'h0000_4d20},
            '{32'h40, 4'hf, 32'h0fff_fffb}, '{32'h40, 4'hf, 32'hffff_fffb},
            '{32'h40, 4'hf, 32'hffff_ffd9},
            '{32'h50, 4'h1, 32'h89ab_cdef}, '{32'h51, 4'h2, 32'habcd_ef00},
            '{32'h52, 4'h4, 32'hcdef_0000}, '{32'h53, 4'h8, 32'hef00_0000},
            '{32'h54, 4'h3, 32'h89ab_cdef}, '{32'h56, 4'hc, 32'hcdef_0000},
            '{32'h44, 4'hf, 32'habcd_e000},
            '{32'h70, 4'hf, 32'hffff_ff81}, '{32'h70, 4'hf, 32'h0000_007e},
            '{32'h70, 4'hf, 32'h0000_00c2}, '{32'h70, 4'hf, 32'h0000_008f},
            '{32'h70, 4'hf, 32'hffff_c281}, '{32'h70, 4'hf, 32'hffff_8f7e},
            '{32'h70, 4'hf, 32'h0000_c281}, '{32'h70, 4'hf, 32'h8f7e_c281},
            '{32'h04, 4'hf, 32'h0000_04d2}, '{32'h0c, 4'hf, 32'h0000_04d2},
            '{32'h14, 4'hf, 32'h0000_04d2}, '{32'h1c, 4'hf, 32'h0000_04d2},
            '{32'h24, 4'hf, 32'h0000_04d2}, '{32'h2c, 4'hf, 32'h0000_04d2}
        };
        wait_for_reset(ok);
        if (ok) begin
            check_bit("bus.as_n", bus.as_n, 1'b1);
            check_bit("bus.we_n", bus.we_n, 1'b1);
            check_bit("halt", halt, 1'b0);
            check_word("pc", pc, start_pc);
            wait_for_halt(ok);
        end
        if (ok) begin
            halt_pc = pc;
            writes  = obs_wr.size();
            check_word("pc", halt_pc, start_pc + 32'(4 * (prog_len - 1)));
            repeat (20) begin
                @(negedge clk);
                check_word("pc", pc, halt_pc);
                check_word("bus.addr", bus.addr, halt_pc);   // fetch address while idle
                check_bit("bus.as_n", bus.as_n, 1'b1);
                check_bit("halt", halt, 1'b1);
            end
            if (obs_wr.size() != writes) begin
                $display("the core wrote to memory after it halted");
                other_count++;
            end
            if (obs_wr.size() != wr_len) begin
                $display("saw %0d memory writes, expected %0d", obs_wr.size(), wr_len);
                other_count++;
            end
            for (int i = 0; i < wr_len && i < obs_wr.size(); i++) begin
                check_word($sformatf("bus.addr of write %0d", i), obs_wr[i].addr,
                           exp_wr[i].addr);
                check_be($sformatf("bus.byte_en of write %0d", i), obs_wr[i].be,
                         exp_wr[i].be);
                check_word($sformatf("bus.wdata of write %0d", i), obs_wr[i].data,
                           exp_wr[i].data);
            end
        end
        report_and_finish();
    end

endmodule
